//--- src.f
+incdir+.
fabric_pkg.sv
config_pkg.sv
config_store.sv
switch_box.sv
connect_box.sv
logic_block.sv
pe_tile.sv
tb_clock_gen.sv
pe_tile_checker.sv
pe_tile_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= pe_tile_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- pe_tile_tb.sv
`include "tile_settings.svh"

module pe_tile_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAND_VECTORS = 64;
	localparam int WRITE_EVERY = 8;
	localparam logic [15:0] MY_TILE = 16'h002A;
	localparam logic [31:0] IDLE = {16'h0000, MY_TILE};
	localparam logic [31:0] WR_SB = {config_pkg::FEAT_SB, MY_TILE};
	localparam logic [31:0] WR_CB0 = {config_pkg::FEAT_CB0, MY_TILE};
	localparam logic [31:0] WR_CB1 = {config_pkg::FEAT_CB1, MY_TILE};
	localparam logic [31:0] WR_LB = {config_pkg::FEAT_LB, MY_TILE};

	logic clk;
	logic arst_n;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	logic [15:0] in_tracks;
	logic [15:0] out_tracks;
	logic pe_out;

	// Table columns
	logic [31:0] row_addr[$];
	logic [31:0] row_data[$];
	logic [15:0] row_in[$];
	logic [15:0] row_out[$];
	logic row_pe[$];

	// Reference model state
	logic [31:0] m_sb;
	logic [2:0] m_cb0;
	logic [2:0] m_cb1;
	logic [1:0] m_lb;
	logic m_pe;

	int cycles = 0;
	int max_cycles = 1000;

	tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

	pe_tile u_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.in_tracks   (in_tracks),
		.out_tracks  (out_tracks),
		.pe_out      (pe_out)
	);

	bind pe_tile pe_tile_checker u_checker (
		.clk        (clk),
		.arst_n     (arst_n),
		.out_tracks (out_tracks),
		.pe_out     (pe_out),
		.sb_cfg     (sb_cfg)
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("test failed");
			$fatal(1, "timeout, the run did not finish within %0d cycles", max_cycles);
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
			$display("test failed");
			$fatal(1, "value check failed on %s", name);
		end
	endtask

	task automatic add_row(input logic [31:0] addr, input logic [31:0] data,
			input logic [15:0] tracks, input logic [15:0] exp_out, input logic exp_pe);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_in.push_back(tracks);
		row_out.push_back(exp_out);
		row_pe.push_back(exp_pe);
	endtask

	// Output side s, track t takes its source from the 2-bit select at index s*4+t
	function automatic logic [15:0] model_route(input logic [15:0] tracks,
			input logic [31:0] sb, input logic pe);
		config_pkg::cfg_word_u w;
		fabric_pkg::sb_sel_e sel;
		logic [15:0] res;
		int idx;
		int src_side;
		w = sb;
		res = '0;
		for (int s = 0; s < `TILE_SIDES; s++) begin
			for (int t = 0; t < `TILE_TRACKS; t++) begin
				idx = s * `TILE_TRACKS + t;
				sel = fabric_pkg::sb_sel_e'(w.sb_view[idx]);
				case (sel)
					fabric_pkg::SB_NEXT:     src_side = (s + 1) % `TILE_SIDES;
					fabric_pkg::SB_OPPOSITE: src_side = (s + 2) % `TILE_SIDES;
					fabric_pkg::SB_PREV:     src_side = (s + 3) % `TILE_SIDES;
					default:                 src_side = s;
				endcase
				if (sel == fabric_pkg::SB_PE)
					res[idx] = pe;
				else
					res[idx] = tracks[src_side * `TILE_TRACKS + t];
			end
		end
		return res;
	endfunction

	function automatic logic pick_operand(input logic [3:0] side_in,
			input logic [3:0] side_sb, input logic [2:0] sel);
		if (sel < 3'd4)
			return side_in[sel[1:0]];
		return side_sb[sel[1:0]];
	endfunction

	function automatic logic apply_op(input logic a, input logic b, input logic [1:0] op);
		logic res;
		case (op)
			fabric_pkg::LB_AND: res = a & b;
			fabric_pkg::LB_OR:  res = a | b;
			fabric_pkg::LB_XOR: res = a ^ b;
			default:            res = ~(a & b);
		endcase
		return res;
	endfunction

	// One clock of the model: next pe_out from this cycle's operands, then the write
	task automatic advance_model(input logic [31:0] addr, input logic [31:0] data,
			input logic [15:0] tracks);
		config_pkg::cfg_word_u w;
		logic [15:0] routed;
		logic a;
		logic b;
		logic next_pe;
		routed = model_route(tracks, m_sb, m_pe);
		a = pick_operand(tracks[3:0], routed[3:0], m_cb0);
		b = pick_operand(tracks[7:4], routed[7:4], m_cb1);
		next_pe = apply_op(a, b, m_lb);
		w = data;
		if (addr[15:0] == tile_id) begin
			case (addr[31:16])
				config_pkg::FEAT_SB:  m_sb = w.sb_view;
				config_pkg::FEAT_CB0: m_cb0 = w.blk_view[2:0];
				config_pkg::FEAT_CB1: m_cb1 = w.blk_view[2:0];
				config_pkg::FEAT_LB:  m_lb = w.blk_view[4:3];
				default: ;
			endcase
		end
		m_pe = next_pe;
	endtask

	task automatic drive_vector(input logic [31:0] addr, input logic [31:0] data,
			input logic [15:0] tracks);
		@(posedge clk);
		#2;
		config_addr = addr;
		config_data = data;
		in_tracks = tracks;
		#17; // Just before the next rising edge
	endtask

	task automatic build_table();
		// Reset defaults, every output copies the next side
		add_row(IDLE, 32'h0, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h1234, 16'h4123, 1'b0);
		add_row(IDLE, 32'h0, 16'h0011, 16'h1001, 1'b0);
		add_row(IDLE, 32'h0, 16'hFFFF, 16'hFFFF, 1'b1);
		add_row(IDLE, 32'h0, 16'h0001, 16'h1000, 1'b1);
		add_row(IDLE, 32'h0, 16'h0000, 16'h0000, 1'b0);
		// Opposite on s0t0 and s2t0, prev on s1t2, compute result on s0t1 and s3t3
		add_row(WR_SB, 32'hC001_200D, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h4321, 16'h1531, 1'b0);
		add_row(IDLE, 32'h0, 16'h0011, 16'h1100, 1'b0);
		add_row(IDLE, 32'h0, 16'h0000, 16'h8002, 1'b1);
		// Connect boxes, cb0 incoming track 2 and cb1 switch box track 1
		add_row(WR_CB0, 32'h2, 16'h0000, 16'h0000, 1'b0);
		add_row(WR_CB1, 32'h5, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h0204, 16'h4060, 1'b0);
		add_row(IDLE, 32'h0, 16'h0004, 16'hC042, 1'b1);
		add_row(WR_CB0, 32'h0, 16'h0000, 16'h0000, 1'b0);
		add_row(WR_CB1, 32'h3, 16'h0000, 16'h0000, 1'b0);
		// Operation walk, a is in bit 0 and b is in bit 7
		add_row(IDLE, 32'h0, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h0001, 16'h1100, 1'b0);
		add_row(IDLE, 32'h0, 16'h0080, 16'h0008, 1'b0);
		add_row(IDLE, 32'h0, 16'h0081, 16'h1108, 1'b0);
		add_row(WR_LB, 32'h08, 16'h0000, 16'h8002, 1'b1);
		add_row(IDLE, 32'h0, 16'h0001, 16'h1100, 1'b0);
		add_row(IDLE, 32'h0, 16'h0080, 16'h800A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0081, 16'h910A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0000, 16'h8002, 1'b1);
		add_row(WR_LB, 32'h10, 16'h0081, 16'h1108, 1'b0);
		add_row(IDLE, 32'h0, 16'h0000, 16'h8002, 1'b1);
		add_row(IDLE, 32'h0, 16'h0001, 16'h1100, 1'b0);
		add_row(IDLE, 32'h0, 16'h0080, 16'h800A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0081, 16'h910A, 1'b1);
		add_row(WR_LB, 32'h18, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h0001, 16'h9102, 1'b1);
		add_row(IDLE, 32'h0, 16'h0080, 16'h800A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0081, 16'h910A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0081, 16'h1108, 1'b0);
		// cb0 on the injected track, NAND feedback toggles
		add_row(WR_CB0, 32'h5, 16'h0000, 16'h0000, 1'b0);
		add_row(IDLE, 32'h0, 16'h0080, 16'h800A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0080, 16'h0008, 1'b0);
		add_row(IDLE, 32'h0, 16'h0080, 16'h800A, 1'b1);
		add_row(IDLE, 32'h0, 16'h0000, 16'h0000, 1'b0);
		// Foreign tile and unknown feature writes are dropped
		add_row({config_pkg::FEAT_SB, MY_TILE + 16'h1}, 32'h0, 16'h0000, 16'h8002, 1'b1);
		add_row({16'h0008, MY_TILE}, 32'h0, 16'h0000, 16'h8002, 1'b1);
		add_row({config_pkg::FEAT_LB, 16'h0000}, 32'h0, 16'h0000, 16'h8002, 1'b1);
		add_row(IDLE, 32'h0, 16'h4321, 16'h9533, 1'b1);
		add_row(IDLE, 32'h0, 16'h0000, 16'h8002, 1'b1);
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [15:0] tracks;
		logic [15:0] exp_out;
		logic [15:0] feat;
		logic [15:0] tile;
		void'($urandom(91));
		config_addr = IDLE;
		config_data = '0;
		tile_id = MY_TILE;
		in_tracks = '0;
		m_sb = '0;
		m_cb0 = '0;
		m_cb1 = '0;
		m_lb = '0;
		m_pe = 1'b0;
		build_table();
		max_cycles = 16 + 2 * row_addr.size() + RAND_VECTORS + 20;
		wait (arst_n === 1'b1);

		for (int r = 0; r < row_addr.size(); r++) begin
			drive_vector(row_addr[r], row_data[r], row_in[r]);
			check_value("out_tracks", 32'(out_tracks), 32'(row_out[r]));
			check_value("pe_out", 32'(pe_out), 32'(row_pe[r]));
			advance_model(row_addr[r], row_data[r], row_in[r]);
		end

		// Random traffic, some writes aimed at a foreign tile or feature 8
		for (int i = 0; i < RAND_VECTORS; i++) begin
			addr = IDLE;
			data = 32'h0;
			if (i % WRITE_EVERY == 0) begin
				feat = 16'(($urandom % 5) + 4);
				tile = ($urandom % 4 == 0) ? (MY_TILE ^ 16'h0001) : MY_TILE;
				addr = {feat, tile};
				data = $urandom;
			end
			tracks = 16'($urandom);
			drive_vector(addr, data, tracks);
			exp_out = model_route(tracks, m_sb, m_pe);
			check_value("out_tracks", 32'(out_tracks), 32'(exp_out));
			check_value("pe_out", 32'(pe_out), 32'(m_pe));
			advance_model(addr, data, tracks);
		end

		$display("test passed");
		$finish;
	end

endmodule

//--- pe_tile_checker.sv
`include "tile_settings.svh"

module pe_tile_checker (
	input logic clk,
	input logic arst_n,
	input logic [`TILE_ALL_TRACKS-1:0] out_tracks,
	input logic pe_out,
	input logic [`CFG_DATA_W-1:0] sb_cfg
);
	timeunit 1ns;
	timeprecision 100ps;

	out_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(out_tracks))
		else $error("out_tracks carries unknown bits after reset release");

	pe_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(pe_out))
		else $error("pe_out is unknown after reset release");

	pe_reset_zero: assert property (@(posedge clk) !arst_n |-> pe_out == 1'b0)
		else $error("pe_out is not zero while reset is asserted");

	// Injected tracks follow the compute result in the same cycle
	for (genvar i = 0; i < `TILE_ALL_TRACKS; i++) begin : g_pe_track
		pe_track: assert property (@(posedge clk) disable iff (!arst_n)
			(sb_cfg[2*i +: 2] == fabric_pkg::SB_PE) |-> (out_tracks[i] == pe_out))
			else $error("track %0d selects the compute result but differs from pe_out", i);
	end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// Release lands just after an edge, like the other inputs
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;
	end

endmodule

//--- pe_tile.sv
`include "tile_settings.svh"

module pe_tile (
	input  logic clk,
	input  logic arst_n,
	input  logic [`CFG_ADDR_W-1:0] config_addr,
	input  logic [`CFG_DATA_W-1:0] config_data,
	input  logic [`TILE_ID_W-1:0] tile_id,
	input  logic [`TILE_ALL_TRACKS-1:0] in_tracks,
	output logic [`TILE_ALL_TRACKS-1:0] out_tracks,
	output logic pe_out
);

	localparam int TRACKS = `TILE_TRACKS;

	logic [`CFG_DATA_W-1:0] sb_cfg;
	logic [fabric_pkg::CB_SEL_W-1:0] cb0_sel;
	logic [fabric_pkg::CB_SEL_W-1:0] cb1_sel;
	fabric_pkg::lb_op_e lb_op;
	logic op_a;
	logic op_b;

	config_store u_cfg (
		.clk         (clk),
		.arst_n      (arst_n),
		.config_addr (config_addr),
		.config_data (config_pkg::cfg_word_u'(config_data)),
		.tile_id     (tile_id),
		.sb_cfg      (sb_cfg),
		.cb0_sel     (cb0_sel),
		.cb1_sel     (cb1_sel),
		.lb_op       (lb_op)
	);

	switch_box u_sb (
		.in_tracks  (in_tracks),
		.pe_out     (pe_out),
		.sb_cfg     (sb_cfg),
		.out_tracks (out_tracks)
	);

	// Operand A from side 0
	connect_box u_cb0 (
		.side_in (in_tracks[0*TRACKS +: TRACKS]),
		.side_sb (out_tracks[0*TRACKS +: TRACKS]),
		.sel     (cb0_sel),
		.operand (op_a)
	);

	// Operand B from side 1
	connect_box u_cb1 (
		.side_in (in_tracks[1*TRACKS +: TRACKS]),
		.side_sb (out_tracks[1*TRACKS +: TRACKS]),
		.sel     (cb1_sel),
		.operand (op_b)
	);

	logic_block u_lb (
		.clk    (clk),
		.arst_n (arst_n),
		.op_a   (op_a),
		.op_b   (op_b),
		.lb_op  (lb_op),
		.pe_out (pe_out)
	);

endmodule

//--- logic_block.sv
module logic_block (
	input  logic clk,
	input  logic arst_n,
	input  logic op_a,
	input  logic op_b,
	input  fabric_pkg::lb_op_e lb_op,
	output logic pe_out
);

	logic result;

	always_comb begin
		case (lb_op)
			fabric_pkg::LB_AND:  result = op_a & op_b;
			fabric_pkg::LB_OR:   result = op_a | op_b;
			fabric_pkg::LB_XOR:  result = op_a ^ op_b;
			default:             result = ~(op_a & op_b); // NAND
		endcase
	end

	// Registered output also breaks the loop through the switch box
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pe_out <= 1'b0;
		end else begin
			pe_out <= result;
		end
	end

endmodule

//--- connect_box.sv
`include "tile_settings.svh"

module connect_box (
	input  logic [`TILE_TRACKS-1:0] side_in,
	input  logic [`TILE_TRACKS-1:0] side_sb,
	input  logic [fabric_pkg::CB_SEL_W-1:0] sel,
	output logic operand
);

	// Low selects pick incoming tracks, high selects the switch box side
	always_comb begin
		case (sel)
			3'd0: operand = side_in[0];
			3'd1: operand = side_in[1];
			3'd2: operand = side_in[2];
			3'd3: operand = side_in[3];
			3'd4: operand = side_sb[0];
			3'd5: operand = side_sb[1];
			3'd6: operand = side_sb[2];
			default: operand = side_sb[3];
		endcase
	end

endmodule

//--- switch_box.sv
`include "tile_settings.svh"

module switch_box (
	input  logic [`TILE_ALL_TRACKS-1:0] in_tracks,
	input  logic pe_out,
	input  logic [`CFG_DATA_W-1:0] sb_cfg,
	output logic [`TILE_ALL_TRACKS-1:0] out_tracks
);

	localparam int SIDES = `TILE_SIDES;
	localparam int TRACKS = `TILE_TRACKS;

	// One 4-to-1 mux per output track
	for (genvar s = 0; s < SIDES; s++) begin : g_side
		for (genvar t = 0; t < TRACKS; t++) begin : g_track
			localparam int IDX = s * TRACKS + t;
			localparam int NEXT_IDX = ((s + 1) % SIDES) * TRACKS + t;
			localparam int OPP_IDX = ((s + 2) % SIDES) * TRACKS + t;
			localparam int PREV_IDX = ((s + 3) % SIDES) * TRACKS + t;

			fabric_pkg::sb_sel_e sel;
			logic routed;

			assign sel = fabric_pkg::sb_sel_e'(sb_cfg[2*IDX +: 2]);

			always_comb begin
				case (sel)
					fabric_pkg::SB_NEXT:     routed = in_tracks[NEXT_IDX];
					fabric_pkg::SB_OPPOSITE: routed = in_tracks[OPP_IDX];
					fabric_pkg::SB_PREV:     routed = in_tracks[PREV_IDX];
					default:                 routed = pe_out; // Compute result injected
				endcase
			end

			assign out_tracks[IDX] = routed;
		end
	end

endmodule

//--- config_store.sv
`include "tile_settings.svh"

module config_store (
	input  logic clk,
	input  logic arst_n,
	input  logic [`CFG_ADDR_W-1:0] config_addr,
	input  config_pkg::cfg_word_u config_data,
	input  logic [`TILE_ID_W-1:0] tile_id,
	output logic [`CFG_DATA_W-1:0] sb_cfg,
	output logic [fabric_pkg::CB_SEL_W-1:0] cb0_sel,
	output logic [fabric_pkg::CB_SEL_W-1:0] cb1_sel,
	output fabric_pkg::lb_op_e lb_op
);

	logic tile_hit;
	config_pkg::feature_e feature;
	logic wr_sb;
	logic wr_cb0;
	logic wr_cb1;
	logic wr_lb;

	// Tile id check is shared by every feature
	assign tile_hit = (config_addr[config_pkg::TILE_MSB:config_pkg::TILE_LSB] == tile_id);
	assign feature = config_pkg::feature_e'(
		config_addr[config_pkg::FEAT_MSB:config_pkg::FEAT_LSB]);

	always_comb begin
		wr_sb = 1'b0;
		wr_cb0 = 1'b0;
		wr_cb1 = 1'b0;
		wr_lb = 1'b0;
		if (tile_hit) begin
			case (feature)
				config_pkg::FEAT_SB:  wr_sb = 1'b1;
				config_pkg::FEAT_CB0: wr_cb0 = 1'b1;
				config_pkg::FEAT_CB1: wr_cb1 = 1'b1;
				config_pkg::FEAT_LB:  wr_lb = 1'b1;
				default: ; // Unknown feature, write dropped
			endcase
		end
	end

	// Switch box takes the full word
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sb_cfg <= '0;
		end else if (wr_sb) begin
			sb_cfg <= config_data.sb_view;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cb0_sel <= '0;
			cb1_sel <= '0;
		end else begin
			if (wr_cb0)
				cb0_sel <= config_data.blk_view[config_pkg::CB_SEL_LSB +: fabric_pkg::CB_SEL_W];
			if (wr_cb1)
				cb1_sel <= config_data.blk_view[config_pkg::CB_SEL_LSB +: fabric_pkg::CB_SEL_W];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lb_op <= fabric_pkg::LB_AND;
		end else if (wr_lb) begin
			lb_op <= fabric_pkg::lb_op_e'(config_data.blk_view[config_pkg::LB_OP_LSB +: 2]);
		end
	end

endmodule

//--- config_pkg.sv
`include "tile_settings.svh"

package config_pkg;

	// Feature code, upper half of config_addr
	typedef enum logic [15:0] {
		FEAT_LB  = 16'd4,
		FEAT_CB1 = 16'd5,
		FEAT_CB0 = 16'd6,
		FEAT_SB  = 16'd7
	} feature_e;

	// Address field positions
	localparam int TILE_LSB = 0;
	localparam int TILE_MSB = `TILE_ID_W - 1;
	localparam int FEAT_LSB = `TILE_ID_W;
	localparam int FEAT_MSB = `CFG_ADDR_W - 1;

	// Field positions inside blk_view
	localparam int CB_SEL_LSB = 0; // Connect box select, bits 2:0
	localparam int LB_OP_LSB = 3; // Logic operation, bits 4:3

	// Two decodings of one configuration word.
	// sb_view[s*4+t] is the 2-bit select for output side s, track t.
	// blk_view carries the connect box select and the logic operation.
	typedef union packed {
		logic [`TILE_ALL_TRACKS-1:0][1:0] sb_view;
		logic [`CFG_DATA_W-1:0] blk_view;
	} cfg_word_u;

endpackage

//--- fabric_pkg.sv
package fabric_pkg;

	// Source of a switch box output on side s
	typedef enum logic [1:0] {
		SB_NEXT     = 2'd0, // Side (s+1) mod 4, same track
		SB_OPPOSITE = 2'd1, // Side (s+2) mod 4
		SB_PREV     = 2'd2, // Side (s+3) mod 4
		SB_PE       = 2'd3  // Compute result
	} sb_sel_e;

	// Connect box select, 0-3 incoming tracks, 4-7 switch box tracks
	localparam int CB_SEL_W = 3;

	// Boolean operation of the logic block
	typedef enum logic [1:0] {
		LB_AND  = 2'd0,
		LB_OR   = 2'd1,
		LB_XOR  = 2'd2,
		LB_NAND = 2'd3
	} lb_op_e;

endpackage

//--- tile_settings.svh
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Routing fabric geometry
`define TILE_SIDES 4
`define TILE_TRACKS 4

// Configuration bus
`define CFG_ADDR_W 32
`define CFG_DATA_W 32

// Tile id sits in the low half of the address
`define TILE_ID_W 16

// Convenience width for the flat track buses
`define TILE_ALL_TRACKS (`TILE_SIDES * `TILE_TRACKS)

`endif
